//--- source/ramio_pkg.sv
/*
 shared encodings for the load/store port: access types, I/O register offsets
 and the 64-bit RAM word as seen by the cache
*/
`default_nettype none

package ramio_pkg;

  localparam int word_bits = 32;  // core data width, fixed

  // store size; the same two bits give the load size in read_type_e
  typedef enum logic [1:0] {
    write_none = 2'b00,
    write_byte = 2'b01,
    write_half = 2'b10,
    write_word = 2'b11
  } write_type_e;

  // bit 2 requests sign extension of bytes and half words
  typedef enum logic [2:0] {
    read_none        = 3'b000,
    read_byte        = 3'b001,
    read_half        = 3'b010,
    read_word        = 3'b011,
    read_byte_signed = 3'b101,
    read_half_signed = 3'b110,
    read_word_signed = 3'b111
  } read_type_e;

  // distance below top_address of each I/O register
  localparam int led_offset      = 0;
  localparam int uart_out_offset = 1;
  localparam int uart_in_offset  = 2;

  // one RAM beat: word view for loads, byte view for masked stores
  typedef union packed {
    logic [1:0][31:0] words;  // picked by address bit 2
    logic [7:0][7:0]  bytes;
  } ram_word_u;

endpackage

`default_nettype wire

//--- source/cache_port_if.sv
/*
 word-aligned request/response bundle between the access decoder and the cache
 requester holds every request field while enable is high
*/
`default_nettype none

interface cache_port_if #(
  parameter int addr_bits = 32
);
  import ramio_pkg::*;

  logic                 enable;
  logic [addr_bits-1:0] address;       // byte address, low two bits zero
  logic [word_bits-1:0] data_in;       // bytes already in their lanes
  logic [3:0]           write_enable;  // zero mask means read
  logic [word_bits-1:0] data_out;
  logic                 data_out_ready;  // access done this cycle
  logic                 busy;            // write-back or fill running

  modport requester (
    output enable, address, data_in, write_enable,
    input  data_out, data_out_ready, busy
  );

  modport cache (
    input  enable, address, data_in, write_enable,
    output data_out, data_out_ready, busy
  );

endinterface

`default_nettype wire

//--- source/uart_tx.sv
/*
 8N1 transmitter, a rising go sends data; bsy holds until the stop bit ends
*/
`default_nettype none

module uart_tx #(
  parameter int clks_per_bit = 8
) (
  input  wire       clk,
  input  wire       rst_n,
  input  wire [7:0] data,
  input  wire       go,
  output logic      tx,
  output logic      bsy
);
  localparam int             cw       = $clog2(clks_per_bit + 1);
  localparam logic [cw-1:0] last_clk = cw'(clks_per_bit - 1);

  logic [cw-1:0] clk_count;
  logic [3:0]    bit_count;  // 0 start, 1..8 data, 9 stop
  logic [8:0]    shift;      // data bits then the stop bit
  logic          go_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx        <= 1'b1;  // line idles high
      bsy       <= 1'b0;
      go_q      <= 1'b0;
      clk_count <= '0;
      bit_count <= '0;
      shift     <= '1;
    end else begin
      go_q <= go;
      if (!bsy) begin
        if (go && !go_q) begin
          bsy       <= 1'b1;
          tx        <= 1'b0;  // start bit
          shift     <= {1'b1, data};
          clk_count <= '0;
          bit_count <= '0;
        end
      end else if (clk_count == last_clk) begin
        clk_count <= '0;
        if (bit_count == 4'd9) begin
          bsy <= 1'b0;  // stop bit done
        end else begin
          tx        <= shift[0];  // LSB first
          shift     <= {1'b1, shift[8:1]};
          bit_count <= bit_count + 4'd1;
        end
      end else begin
        clk_count <= clk_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/uart_rx.sv
/*
 8N1 receiver sampling each bit at mid-period
 with go high a finished byte raises dr, which holds until go drops
*/
`default_nettype none

module uart_rx #(
  parameter int clks_per_bit = 8
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        rx,
  input  wire        go,
  output logic [7:0] data,  // shifting in, complete when dr rises
  output logic       dr
);
  localparam int            cw         = $clog2(clks_per_bit + 1);
  localparam logic [cw-1:0] last_clk   = cw'(clks_per_bit - 1);
  localparam logic [cw-1:0] half_start = cw'(clks_per_bit - clks_per_bit / 2);

  logic [1:0]    rx_sync;  // two-flop synchronizer
  logic          active;
  logic [cw-1:0] clk_count;
  logic [3:0]    bit_count;  // 0 start, 1..8 data, 9 stop

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync   <= 2'b11;
      active    <= 1'b0;
      clk_count <= '0;
      bit_count <= '0;
      data      <= '0;
      dr        <= 1'b0;
    end else begin
      rx_sync <= {rx_sync[0], rx};
      if (!go) dr <= 1'b0;  // acknowledged
      if (!active) begin
        if (!rx_sync[1]) begin  // start edge
          active    <= 1'b1;
          clk_count <= half_start;  // first sample half a bit in
          bit_count <= '0;
        end
      end else if (clk_count == last_clk) begin
        clk_count <= '0;
        if (bit_count == 4'd0) begin
          if (rx_sync[1]) active <= 1'b0;  // glitch, not a start bit
          else bit_count <= 4'd1;
        end else if (bit_count == 4'd9) begin
          active <= 1'b0;
          if (go) dr <= 1'b1;
        end else begin
          data      <= {rx_sync[1], data[7:1]};  // LSB arrives first
          bit_count <= bit_count + 4'd1;
        end
      end else begin
        clk_count <= clk_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/ram_io.sv
/*
 load/store decoder: sends RAM addresses to the cache with byte lanes lined up,
 extends loads by read type and keeps the LED and UART registers at the top
*/
`default_nettype none

module ram_io #(
  parameter int                   addr_bits   = 32,
  parameter logic [addr_bits-1:0] top_address = '1
) (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire                              enable,
  input  var  ramio_pkg::write_type_e      write_type,
  input  var  ramio_pkg::read_type_e       read_type,
  input  wire [addr_bits-1:0]              address,
  input  wire [ramio_pkg::word_bits-1:0]   data_in,
  output logic [ramio_pkg::word_bits-1:0]  data_out,
  output logic                             data_out_ready,
  output logic                             busy,
  output logic [3:0]                       led,
  cache_port_if.requester                  cache,
  output logic [7:0]                       tx_data,  // byte being sent
  output logic                             tx_go,
  input  wire                              tx_bsy,
  output logic                             rx_go,
  input  wire  [7:0]                       rx_data,
  input  wire                              rx_dr
);
  import ramio_pkg::*;

  localparam logic [addr_bits-1:0] led_address      = top_address - addr_bits'(led_offset);
  localparam logic [addr_bits-1:0] uart_out_address = top_address - addr_bits'(uart_out_offset);
  localparam logic [addr_bits-1:0] uart_in_address  = top_address - addr_bits'(uart_in_offset);

  logic       is_led;
  logic       is_uart_out;
  logic       is_uart_in;
  logic       is_io;
  logic       rd_byte;   // load size is a byte
  logic       wr_byte;   // store size is a byte
  logic [7:0] rx_byte;   // last received byte, zero once read
  logic       tx_bsy_q;  // for the falling edge of bsy

  // zero or sign fill of a byte (half low) or half word (half high)
  function automatic logic [word_bits-1:0] extend(input logic [15:0] value,
                                                  input logic        half,
                                                  input logic        sign);
    logic fill;
    fill = sign & (half ? value[15] : value[7]);
    return half ? {{16{fill}}, value} : {{24{fill}}, value[7:0]};
  endfunction

  assign is_led      = address == led_address;
  assign is_uart_out = address == uart_out_address;
  assign is_uart_in  = address == uart_in_address;
  assign is_io       = is_led | is_uart_out | is_uart_in;
  assign rd_byte     = read_type[1:0] == write_byte;
  assign wr_byte     = write_type == write_byte;

  // I/O answers at once, RAM follows the cache
  assign busy           = is_io ? 1'b0 : cache.busy;
  assign data_out_ready = is_io ? 1'b1 : cache.data_out_ready;

  // store side: byte enables and lanes from size and low address bits
  always_comb begin
    cache.enable       = enable && !is_io;
    cache.address      = {address[addr_bits-1:2], 2'b00};
    cache.write_enable = 4'b0000;
    cache.data_in      = '0;
    case (write_type)
      write_byte: begin
        cache.write_enable = 4'b0001 << address[1:0];
        cache.data_in      = {4{data_in[7:0]}};  // mask picks the lane
      end
      write_half: begin
        if (!address[0]) begin  // odd address stores nothing
          cache.write_enable = address[1] ? 4'b1100 : 4'b0011;
          cache.data_in      = {2{data_in[15:0]}};
        end
      end
      write_word: begin
        if (address[1:0] == 2'b00) begin
          cache.write_enable = 4'b1111;
          cache.data_in      = data_in;
        end
      end
      default: ;  // plain read
    endcase
  end

  // load side
  always_comb begin
    data_out = '0;
    if (is_uart_out) begin
      if (rd_byte) data_out = extend({8'h00, tx_data}, 1'b0, read_type[2]);
    end else if (is_uart_in) begin
      if (rd_byte) data_out = extend({8'h00, rx_byte}, 1'b0, read_type[2]);
    end else if (!is_led) begin
      case (read_type[1:0])
        2'b01: data_out = extend({8'h00, cache.data_out[8*address[1:0] +: 8]}, 1'b0,
                                 read_type[2]);
        2'b10: begin
          if (!address[0]) begin  // misaligned half reads zero
            data_out = extend(cache.data_out[16*address[1] +: 16], 1'b1, read_type[2]);
          end
        end
        2'b11: begin
          if (address[1:0] == 2'b00) data_out = cache.data_out;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      led      <= 4'b1111;  // all LEDs off
      tx_data  <= '0;
      tx_go    <= 1'b0;
      tx_bsy_q <= 1'b0;
      rx_byte  <= '0;
      rx_go    <= 1'b1;  // receiver armed from the start
    end else begin
      tx_bsy_q <= tx_bsy;
      if (enable && is_uart_in && rd_byte) begin
        rx_byte <= '0;  // consumed by the load
      end else if (rx_go && rx_dr) begin
        rx_byte <= rx_data;
        rx_go   <= 1'b0;  // one-cycle acknowledge
      end
      if (!rx_go) rx_go <= 1'b1;  // re-arm after the ack
      // frame finished, release go
      if (tx_go && tx_bsy_q && !tx_bsy) begin
        tx_go   <= 1'b0;
        tx_data <= '0;
      end
      if (enable && is_uart_out && wr_byte) begin
        tx_data <= data_in[7:0];  // replaces a pending byte
        tx_go   <= 1'b1;
      end
      if (enable && is_led && wr_byte) led <= data_in[3:0];
    end
  end

endmodule

`default_nettype wire

//--- source/line_cache.sv
/*
 direct-mapped write-back cache, one 64-bit RAM beat per line
 misses write back a dirty victim, then fill with a single-beat burst read
*/
`default_nettype none

module line_cache #(
  parameter int ram_depth_bits  = 10,
  parameter int line_index_bits = 1
) (
  input  wire                       clk,
  input  wire                       rst_n,
  cache_port_if.cache               cache,
  output logic                      br_cmd,        // 0 read, 1 write
  output logic                      br_cmd_en,     // one-cycle strobe
  output logic [ram_depth_bits-1:0] br_addr,       // 64-bit word address
  output logic [63:0]               br_wr_data,
  output logic [7:0]                br_data_mask,
  input  wire  [63:0]               br_rd_data,
  input  wire                       br_rd_data_valid
);
  import ramio_pkg::*;

  localparam int lines    = 2 ** line_index_bits;
  localparam int tag_bits = ram_depth_bits - line_index_bits;

  localparam logic [1:0] st_idle       = 2'd0;
  localparam logic [1:0] st_respond    = 2'd1;
  localparam logic [1:0] st_write_back = 2'd2;
  localparam logic [1:0] st_fill       = 2'd3;

  logic [1:0]                state;
  ram_word_u                 line_data [lines];
  logic [tag_bits-1:0]       line_tag  [lines];
  logic [lines-1:0]          line_valid;
  logic [lines-1:0]          line_dirty;
  logic [ram_depth_bits-1:0] word_addr;
  logic [line_index_bits-1:0] index;
  logic [tag_bits-1:0]       tag;
  logic                      hit;
  logic                      do_write;
  ram_word_u                 wr_word;  // store data in both halves
  logic [7:0]                wr_mask;  // byte enables over the beat

  assign word_addr = cache.address[3 +: ram_depth_bits];
  assign index     = word_addr[line_index_bits-1:0];
  assign tag       = word_addr[ram_depth_bits-1:line_index_bits];
  assign hit       = line_valid[index] && line_tag[index] == tag;
  assign do_write  = state == st_idle && cache.enable && hit && |cache.write_enable;

  assign wr_word.words = {2{cache.data_in}};
  assign wr_mask       = cache.address[2] ? {cache.write_enable, 4'b0000}
                                          : {4'b0000, cache.write_enable};

  assign cache.data_out       = line_data[index].words[cache.address[2]];
  assign cache.data_out_ready = state == st_respond;
  assign cache.busy           = state == st_write_back || state == st_fill;
  assign br_data_mask         = '0;  // full-beat writes only

  // line storage, merged bytes on a write hit or a whole beat on a fill
  always_ff @(posedge clk) begin
    if (do_write) begin
      for (int b = 0; b < 8; b++) begin
        if (wr_mask[b]) line_data[index].bytes[b] <= wr_word.bytes[b];
      end
    end else if (state == st_fill && br_rd_data_valid) begin
      line_data[index] <= br_rd_data;
      line_tag[index]  <= tag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_idle;
      line_valid <= '0;
      line_dirty <= '0;
      br_cmd     <= 1'b0;
      br_cmd_en  <= 1'b0;
      br_addr    <= '0;
      br_wr_data <= '0;
    end else begin
      br_cmd_en <= 1'b0;
      case (state)
        st_idle: begin
          if (cache.enable) begin
            if (hit) begin
              state <= st_respond;
              if (|cache.write_enable) line_dirty[index] <= 1'b1;
            end else if (line_valid[index] && line_dirty[index]) begin
              state      <= st_write_back;  // evict victim first
              br_cmd_en  <= 1'b1;
              br_cmd     <= 1'b1;
              br_addr    <= {line_tag[index], index};
              br_wr_data <= line_data[index];
            end else begin
              state     <= st_fill;
              br_cmd_en <= 1'b1;
              br_cmd    <= 1'b0;
              br_addr   <= word_addr;
            end
          end
        end
        st_respond: state <= st_idle;
        st_write_back: begin  // write done at its command, now fetch
          state     <= st_fill;
          br_cmd_en <= 1'b1;
          br_cmd    <= 1'b0;
          br_addr   <= word_addr;
        end
        st_fill: begin
          if (br_rd_data_valid) begin
            state             <= st_idle;  // retried as a hit
            line_valid[index] <= 1'b1;
            line_dirty[index] <= 1'b0;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/ramio_top.sv
/*
 load/store port top: decoder, line cache and UARTs, burst RAM on br_ ports
 clks_per_bit defaults to clock_hz / baud_rate
*/
`default_nettype none

module ramio_top #(
  parameter int                   addr_bits       = 32,
  parameter int                   ram_depth_bits  = 10,
  parameter int                   line_index_bits = 1,
  parameter logic [addr_bits-1:0] top_address     = '1,
  parameter int                   clock_hz        = 20_250_000,
  parameter int                   baud_rate       = 9600,
  parameter int                   clks_per_bit    = clock_hz / baud_rate
) (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             enable,
  input  var  ramio_pkg::write_type_e     write_type,
  input  var  ramio_pkg::read_type_e      read_type,
  input  wire [addr_bits-1:0]             address,
  input  wire [ramio_pkg::word_bits-1:0]  data_in,
  output logic [ramio_pkg::word_bits-1:0] data_out,
  output logic                            data_out_ready,
  output logic                            busy,
  output logic [3:0]                      led,
  output logic                            uart_tx,
  input  wire                             uart_rx,
  output logic                            br_cmd,
  output logic                            br_cmd_en,
  output logic [ram_depth_bits-1:0]       br_addr,
  output logic [63:0]                     br_wr_data,
  output logic [7:0]                      br_data_mask,
  input  wire  [63:0]                     br_rd_data,
  input  wire                             br_rd_data_valid
);
  logic [7:0] tx_data;
  logic       tx_go;
  logic       tx_bsy;
  logic       rx_go;
  logic [7:0] rx_data;
  logic       rx_dr;

  cache_port_if #(.addr_bits(addr_bits)) cache_port ();

  ram_io #(
    .addr_bits  (addr_bits),
    .top_address(top_address)
  ) ram_io_inst (
    .clk, .rst_n, .enable, .write_type, .read_type, .address, .data_in,
    .data_out, .data_out_ready, .busy, .led,
    .cache(cache_port.requester),
    .tx_data, .tx_go, .tx_bsy, .rx_go, .rx_data, .rx_dr
  );

  line_cache #(
    .ram_depth_bits (ram_depth_bits),
    .line_index_bits(line_index_bits)
  ) line_cache_inst (
    .clk, .rst_n,
    .cache(cache_port.cache),
    .br_cmd, .br_cmd_en, .br_addr, .br_wr_data, .br_data_mask,
    .br_rd_data, .br_rd_data_valid
  );

  uart_tx #(.clks_per_bit(clks_per_bit)) uart_tx_inst (
    .clk, .rst_n, .data(tx_data), .go(tx_go), .tx(uart_tx), .bsy(tx_bsy)
  );

  uart_rx #(.clks_per_bit(clks_per_bit)) uart_rx_inst (
    .clk, .rst_n, .rx(uart_rx), .go(rx_go), .data(rx_data), .dr(rx_dr)
  );

endmodule

`default_nettype wire

//--- verification/burst_ram_model.sv
/*
 behavioral 64-bit burst RAM for the testbench, single-beat commands only
 writes land at their command, reads answer read_delay cycles later
*/
`default_nettype none

module burst_ram_model #(
  parameter int depth_bits = 10,
  parameter int read_delay = 4
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  cmd,        // 0 read, 1 write
  input  wire                  cmd_en,
  input  wire [depth_bits-1:0] addr,       // 64-bit word address
  input  wire [63:0]           wr_data,
  input  wire [7:0]            data_mask,  // set bit keeps the stored byte
  output logic [63:0]          rd_data,
  output logic                 rd_data_valid
);
  logic [63:0]           mem [2**depth_bits];
  logic [depth_bits-1:0] rd_addr;    // word of the pending read
  int                    countdown;  // cycles left until the read answers

  // each byte starts from a value tied to its full byte address
  initial begin
    for (int a = 0; a < 8 * 2**depth_bits; a++) begin
      mem[a / 8][8*(a % 8) +: 8] = 8'(a ^ (a >> 8) ^ 'h5a);
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data       <= '0;
      rd_data_valid <= 1'b0;
      rd_addr       <= '0;
      countdown     <= 0;
    end else begin
      rd_data_valid <= 1'b0;  // one-cycle strobe
      if (cmd_en && cmd) begin
        for (int b = 0; b < 8; b++) begin
          if (!data_mask[b]) mem[addr][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
      if (cmd_en && !cmd) begin
        rd_addr   <= addr;
        countdown <= read_delay;
      end else if (countdown > 0) begin
        countdown <= countdown - 1;
        if (countdown == 1) begin
          rd_data       <= mem[rd_addr];
          rd_data_valid <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_ramio.sv
/*
 testbench for the load/store port: a table of stores, loads, LED and UART steps
 loads are checked against a byte-array reference memory, UART frames are decoded
*/
`default_nettype none

module tb_ramio;
  import ramio_pkg::*;

  localparam int          ram_depth_bits = 10;
  localparam int          bit_clks       = 8;             // UART bit period
  localparam int          frame_clks     = 11 * bit_clks; // 10 bits plus slack
  localparam int          reset_clks     = 16;
  localparam logic [31:0] led_addr       = 32'hffff_ffff - 32'(led_offset);
  localparam logic [31:0] uart_out_addr  = 32'hffff_ffff - 32'(uart_out_offset);
  localparam logic [31:0] uart_in_addr   = 32'hffff_ffff - 32'(uart_in_offset);

  localparam int op_write = 0;
  localparam int op_read  = 1;
  localparam int op_led   = 2;  // led must show data[3:0]
  localparam int op_tx    = 3;  // next uart_tx frame carries data[7:0]
  localparam int op_rx    = 4;  // drive data[7:0] as a frame on uart_rx

  typedef struct {
    int          op;
    logic [31:0] addr;
    logic [2:0]  kind;  // write type or read type
    logic [31:0] data;
  } step_t;

  logic                      clk;
  logic                      rst_n;
  logic                      enable;
  write_type_e               write_type;
  read_type_e                read_type;
  logic [31:0]               address;
  logic [31:0]               data_in;
  logic [31:0]               data_out;
  logic                      data_out_ready;
  logic                      busy;
  logic [3:0]                led;
  logic                      uart_tx;
  logic                      uart_rx;
  logic                      br_cmd;
  logic                      br_cmd_en;
  logic [ram_depth_bits-1:0] br_addr;
  logic [63:0]               br_wr_data;
  logic [7:0]                br_data_mask;
  logic [63:0]               br_rd_data;
  logic                      br_rd_data_valid;

  logic [7:0] ref_mem [2**(ram_depth_bits+3)];  // one entry per RAM byte
  logic [7:0] tx_ref;         // byte last written to UART out
  logic [7:0] rx_ref;         // byte waiting in UART in
  logic [7:0] tx_frames [$];  // bytes decoded from uart_tx
  step_t      steps [$];
  int         cycles      = 0;
  int         cycle_limit = 0;

  ramio_top #(
    .ram_depth_bits (ram_depth_bits),
    .line_index_bits(1),
    .clks_per_bit   (bit_clks)
  ) ramio_top_inst (
    .clk, .rst_n, .enable, .write_type, .read_type, .address, .data_in,
    .data_out, .data_out_ready, .busy, .led, .uart_tx, .uart_rx,
    .br_cmd, .br_cmd_en, .br_addr, .br_wr_data, .br_data_mask,
    .br_rd_data, .br_rd_data_valid
  );

  burst_ram_model #(.depth_bits(ram_depth_bits), .read_delay(4)) burst_ram_inst (
    .clk, .rst_n, .cmd(br_cmd), .cmd_en(br_cmd_en), .addr(br_addr),
    .wr_data(br_wr_data), .data_mask(br_data_mask),
    .rd_data(br_rd_data), .rd_data_valid(br_rd_data_valid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout, the run did not finish within %0d cycles", cycle_limit);
    end
  end

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "mismatch");
    end
  endtask

  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a ^ (a >> 8) ^ 'h5a);  // same start value as the RAM model
  endfunction

  // byte (size 01) or half word (size 10), zero or sign filled
  function automatic logic [31:0] extended(input logic [31:0] raw, input logic [1:0] size,
                                           input logic sign);
    if (size == 2'b01) return sign ? 32'($signed(raw[7:0])) : 32'(raw[7:0]);
    if (size == 2'b10) return sign ? 32'($signed(raw[15:0])) : 32'(raw[15:0]);
    return raw;
  endfunction

  function automatic void store_ref(input logic [31:0] addr, input logic [1:0] wt,
                                    input logic [31:0] value);
    int a;
    a = int'(addr[12:0]);
    if (addr == uart_out_addr) begin
      if (wt == write_byte) tx_ref = value[7:0];
    end else if (addr != led_addr && addr != uart_in_addr) begin
      case (wt)
        write_byte: ref_mem[a] = value[7:0];
        write_half: if (!addr[0]) {ref_mem[a+1], ref_mem[a]} = value[15:0];
        write_word: if (addr[1:0] == 2'b00)
          {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]} = value;
        default: ;
      endcase
    end
  endfunction

  function automatic logic [31:0] load_ref(input logic [31:0] addr, input logic [2:0] rt);
    int          a;
    logic [31:0] raw;
    a   = int'(addr[12:0]);
    raw = '0;
    if (addr == led_addr) return '0;
    if (addr == uart_out_addr || addr == uart_in_addr) begin
      if (rt[1:0] != 2'b01) return '0;  // registers answer byte loads only
      raw = {24'd0, ((addr == uart_out_addr) ? tx_ref : rx_ref)};
    end else begin
      case (rt[1:0])
        2'b01: raw = {24'd0, ref_mem[a]};
        2'b10: begin
          if (addr[0]) return '0;  // odd half word
          raw = {16'd0, ref_mem[a+1], ref_mem[a]};
        end
        2'b11: begin
          if (addr[1:0] != 2'b00) return '0;
          raw = {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
        end
        default: return '0;
      endcase
    end
    return extended(raw, rt[1:0], rt[2]);
  endfunction

  function automatic void add_step(input int op, input logic [31:0] addr,
                                   input logic [2:0] kind, input logic [31:0] data);
    steps.push_back('{op, addr, kind, data});
  endfunction

  function automatic void build_steps();
    // stores of every size, loads of every lane, signed and unsigned
    add_step(op_write, 32'h100, write_word, $urandom);
    add_step(op_read,  32'h100, read_word, 0);
    add_step(op_write, 32'h101, write_byte, $urandom);
    add_step(op_write, 32'h103, write_byte, 32'h80);  // sign bit set
    for (int lane = 0; lane < 4; lane++) begin
      add_step(op_read, 32'h100 + lane, read_byte, 0);
      add_step(op_read, 32'h100 + lane, read_byte_signed, 0);
    end
    add_step(op_write, 32'h104, write_half, $urandom);
    add_step(op_write, 32'h106, write_half, 32'h8001);
    add_step(op_write, 32'h10b, write_half, $urandom);  // odd, stores nothing
    add_step(op_write, 32'h10a, write_word, $urandom);  // misaligned word
    add_step(op_read,  32'h104, read_half, 0);
    add_step(op_read,  32'h106, read_half_signed, 0);
    add_step(op_read,  32'h106, read_half, 0);
    add_step(op_read,  32'h105, read_half, 0);  // reads zero
    add_step(op_read,  32'h107, read_half_signed, 0);
    add_step(op_read,  32'h104, read_word, 0);
    add_step(op_read,  32'h108, read_word, 0);  // untouched, start value
    add_step(op_read,  32'h10a, read_word, 0);
    add_step(op_read,  32'h10b, read_byte_signed, 0);
    // 0x100, 0x200, 0x210 and 0x224 all share line 0
    add_step(op_write, 32'h200, write_word, $urandom);
    add_step(op_write, 32'h210, write_word, $urandom);
    add_step(op_write, 32'h224, write_word, $urandom);
    add_step(op_write, 32'h212, write_half, $urandom);
    add_step(op_read,  32'h200, read_word, 0);
    add_step(op_read,  32'h210, read_word, 0);
    add_step(op_read,  32'h224, read_word, 0);
    add_step(op_read,  32'h100, read_word, 0);
    add_step(op_read,  32'h106, read_half_signed, 0);
    // LED takes byte stores only
    add_step(op_write, led_addr, write_byte, 32'h36);
    add_step(op_led,   0, 0, 32'h6);
    add_step(op_write, led_addr, write_word, 32'h9);
    add_step(op_write, 32'h10, write_word, 32'h9);
    add_step(op_led,   0, 0, 32'h6);
    add_step(op_read,  32'h10, read_word, 0);
    // UART out, read back while the frame is on the line
    add_step(op_write, uart_out_addr, write_byte, 32'ha5);
    add_step(op_read,  uart_out_addr, read_byte, 0);
    add_step(op_read,  uart_out_addr, read_byte_signed, 0);
    add_step(op_tx,    0, 0, 32'ha5);
    // UART in, a byte load empties the register
    add_step(op_rx,    0, 0, 32'hc3);
    add_step(op_read,  uart_in_addr, read_byte_signed, 0);
    add_step(op_read,  uart_in_addr, read_byte, 0);
    add_step(op_rx,    0, 0, 32'h9c);
    add_step(op_read,  uart_in_addr, read_byte, 0);
    add_step(op_read,  uart_in_addr, read_byte_signed, 0);
  endfunction

  // request held from a falling edge until data_out_ready at a rising edge
  task automatic access(input logic [31:0] addr, input write_type_e wt, input read_type_e rt,
                        input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge clk);
    enable     = 1'b1;
    address    = addr;
    write_type = wt;
    read_type  = rt;
    data_in    = wdata;
    @(posedge clk);
    while (!data_out_ready) @(posedge clk);  // values from before the edge
    rdata = data_out;
    @(negedge clk);
    enable     = 1'b0;
    write_type = write_none;
    read_type  = read_none;
  endtask

  task automatic send_rx_frame(input logic [7:0] value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};  // stop, data LSB first, start
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      uart_rx = frame[i];
      repeat (bit_clks - 1) @(negedge clk);
    end
    repeat (2) @(negedge clk);  // byte handed over after the stop sample
  endtask

  // decodes uart_tx at mid-bit on falling clock edges
  initial begin : tx_decoder
    logic [7:0] value;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge uart_tx);
      repeat (bit_clks / 2) @(negedge clk);
      check(uart_tx, 1'b0, "uart_tx start bit");
      for (int i = 0; i < 8; i++) begin
        repeat (bit_clks) @(negedge clk);
        value[i] = uart_tx;
      end
      repeat (bit_clks) @(negedge clk);
      check(uart_tx, 1'b1, "uart_tx stop bit");
      tx_frames.push_back(value);
    end
  end

  initial begin : run
    logic [31:0] rdata;
    logic [31:0] expected;
    int          frames;
    void'($urandom(44490));
    rst_n      = 1'b0;
    enable     = 1'b0;
    write_type = write_none;
    read_type  = read_none;
    address    = '0;
    data_in    = '0;
    uart_rx    = 1'b1;  // line idle
    tx_ref     = '0;
    rx_ref     = '0;
    frames     = 0;
    for (int a = 0; a < 2**(ram_depth_bits+3); a++) ref_mem[a] = fill_byte(a);
    build_steps();
    foreach (steps[i]) if (steps[i].op == op_tx || steps[i].op == op_rx) frames++;
    cycle_limit = reset_clks + 8 + steps.size() * 20 + frames * frame_clks;

    repeat (reset_clks) begin
      @(posedge clk);
      @(negedge clk);
      check(br_cmd_en, 1'b0, "br_cmd_en in reset");
    end
    rst_n = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check(led, 4'hf, "led after reset");
      check(uart_tx, 1'b1, "uart_tx after reset");
      check(busy, 1'b0, "busy after reset");
      check(data_out_ready, 1'b0, "data_out_ready after reset");
      check(br_cmd_en, 1'b0, "br_cmd_en after reset");
    end

    foreach (steps[i]) begin
      case (steps[i].op)
        op_write: begin
          access(steps[i].addr, write_type_e'(steps[i].kind[1:0]), read_none,
                 steps[i].data, rdata);
          store_ref(steps[i].addr, steps[i].kind[1:0], steps[i].data);
        end
        op_read: begin
          expected = load_ref(steps[i].addr, steps[i].kind);
          access(steps[i].addr, write_none, read_type_e'(steps[i].kind), '0, rdata);
          check(rdata, expected, $sformatf("step %0d load at %h", i, steps[i].addr));
          if (steps[i].addr == uart_in_addr && steps[i].kind[1:0] == 2'b01) rx_ref = '0;
        end
        op_led: begin
          @(negedge clk);
          check(led, steps[i].data[3:0], $sformatf("step %0d led", i));
        end
        op_tx: begin
          while (tx_frames.size() == 0) @(negedge clk);  // bounded by the timeout
          check(tx_frames.pop_front(), steps[i].data[7:0], $sformatf("step %0d frame", i));
        end
        op_rx: begin
          send_rx_frame(steps[i].data[7:0]);
          rx_ref = steps[i].data[7:0];
        end
        default: ;
      endcase
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
source/ramio_pkg.sv
source/cache_port_if.sv
source/uart_tx.sv
source/uart_rx.sv
source/ram_io.sv
source/line_cache.sv
source/ramio_top.sv
verification/burst_ram_model.sv
verification/tb_ramio.sv

//--- Bender.yml
package:
  name: ramio

sources:
  - files:
      - source/ramio_pkg.sv
      - source/cache_port_if.sv
      - source/uart_tx.sv
      - source/uart_rx.sv
      - source/ram_io.sv
      - source/line_cache.sv
      - source/ramio_top.sv
  - target: test
    files:
      - verification/burst_ram_model.sv
      - verification/tb_ramio.sv
